//--- clk_rst_pkg.sv
`default_nettype none

package clk_rst_pkg;

  localparam int unsigned num_clocks = 4;
  localparam int unsigned div_width = 8;
  localparam int unsigned axil_addr_width = 8;
  localparam int unsigned axil_data_width = 32;
  localparam int unsigned axil_strb_width = axil_data_width / 8;

  typedef logic [div_width-1:0] div_t;
  typedef div_t [num_clocks-1:0] div_array_t;

  // Register map, byte offsets
  localparam logic [axil_addr_width-1:0] addr_division = 8'h00;
  localparam logic [axil_addr_width-1:0] addr_apply = 8'h04;
  localparam logic [axil_addr_width-1:0] addr_reset = 8'h08;

  localparam logic [1:0] axil_resp_okay = 2'b00;
  localparam logic [1:0] axil_resp_slverr = 2'b10;

  // Channel 0 sits in the low byte
  localparam div_array_t default_division = {8'd4, 8'd3, 8'd2, 8'd1};
  localparam int unsigned reset_stages [num_clocks] = '{2, 3, 4, 5};

  // One bus word, per-channel factors or a flat bit mask
  typedef union packed {
    div_array_t division;
    logic [axil_data_width-1:0] mask;
  } reg_word_u;

  typedef struct packed {
    logic [axil_addr_width-1:0] aw_addr;
    logic aw_valid;
    logic [axil_data_width-1:0] w_data;
    logic [axil_strb_width-1:0] w_strb;
    logic w_valid;
    logic b_ready;
    logic [axil_addr_width-1:0] ar_addr;
    logic ar_valid;
    logic r_ready;
  } axil_req_t;

  typedef struct packed {
    logic aw_ready;
    logic w_ready;
    logic [1:0] b_resp;
    logic b_valid;
    logic ar_ready;
    logic [axil_data_width-1:0] r_data;
    logic [1:0] r_resp;
    logic r_valid;
  } axil_rsp_t;

  typedef struct packed {
    div_t divisor;
    logic apply;
    logic reset;
  } chan_ctrl_t;

endpackage

`default_nettype wire

//--- clk_rst_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rst_axil_regs (
  input  wire logic                   mst_clk_i,
  input  wire logic                   mst_rst_n_d2_mst_clk,
  input  wire clk_rst_pkg::axil_req_t axil_req_i,
  output clk_rst_pkg::axil_rsp_t      axil_rsp_o,
  output clk_rst_pkg::chan_ctrl_t [clk_rst_pkg::num_clocks-1:0] chan_ctrl_o
);

  import clk_rst_pkg::*;

  logic wr_fire;
  logic rd_fire;
  logic wr_addr_ok;
  logic rd_addr_ok;
  reg_word_u wr_word;
  reg_word_u rd_word;

  div_array_t division_q;
  logic [num_clocks-1:0] apply_q;
  logic [num_clocks-1:0] reset_q;

  logic b_valid_q;
  logic [1:0] b_resp_q;
  logic r_valid_q;
  logic [1:0] r_resp_q;
  logic [axil_data_width-1:0] r_data_q;

  // Address and data are taken together, one write in flight
  assign wr_fire = axil_req_i.aw_valid && axil_req_i.w_valid && !b_valid_q;
  assign rd_fire = axil_req_i.ar_valid && !r_valid_q;

  assign wr_word = axil_req_i.w_data;
  assign wr_addr_ok = axil_req_i.aw_addr inside {addr_division, addr_apply, addr_reset};
  assign rd_addr_ok = axil_req_i.ar_addr inside {addr_division, addr_apply, addr_reset};

  // Pulse registers and unmapped space read as zero
  always_comb begin
    rd_word.mask = '0;
    if (axil_req_i.ar_addr == addr_division) begin
      rd_word.division = division_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge mst_clk_i or negedge mst_rst_n_d2_mst_clk) begin
    if (!mst_rst_n_d2_mst_clk) begin
      division_q <= default_division;
      apply_q <= '0;
      reset_q <= '0;
    end else begin
      apply_q <= '0;
      reset_q <= '0;
      if (wr_fire) begin
        if (axil_req_i.aw_addr == addr_division) begin
          // Byte lane i holds channel i
          for (int i = 0; i < num_clocks; i++) begin
            if (axil_req_i.w_strb[i]) begin
              division_q[i] <= wr_word.division[i];
            end
          end
        end
        if (axil_req_i.aw_addr == addr_apply && axil_req_i.w_strb[0]) begin
          apply_q <= wr_word.mask[num_clocks-1:0];
        end
        if (axil_req_i.aw_addr == addr_reset && axil_req_i.w_strb[0]) begin
          reset_q <= wr_word.mask[num_clocks-1:0];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < num_clocks; i++) begin
      chan_ctrl_o[i].divisor = division_q[i];
      chan_ctrl_o[i].apply = apply_q[i];
      chan_ctrl_o[i].reset = reset_q[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response channels
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge mst_clk_i or negedge mst_rst_n_d2_mst_clk) begin
    if (!mst_rst_n_d2_mst_clk) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge mst_clk_i) begin
    if (wr_fire) begin
      b_resp_q <= wr_addr_ok ? axil_resp_okay : axil_resp_slverr;
    end
    if (rd_fire) begin
      r_resp_q <= rd_addr_ok ? axil_resp_okay : axil_resp_slverr;
      r_data_q <= rd_word.mask;
    end
  end

  always_comb begin
    axil_rsp_o.aw_ready = wr_fire;
    axil_rsp_o.w_ready = wr_fire;
    axil_rsp_o.b_resp = b_resp_q;
    axil_rsp_o.b_valid = b_valid_q;
    axil_rsp_o.ar_ready = !r_valid_q;
    axil_rsp_o.r_data = r_data_q;
    axil_rsp_o.r_resp = r_resp_q;
    axil_rsp_o.r_valid = r_valid_q;
  end

  // A pending response keeps its payload until the master takes it
  b_valid_hold_a : assert property (
    @(posedge mst_clk_i) disable iff (!mst_rst_n_d2_mst_clk)
    b_valid_q && !axil_req_i.b_ready |=> b_valid_q && $stable(b_resp_q)
  ) else $error("b_valid dropped before b_ready");

  r_valid_hold_a : assert property (
    @(posedge mst_clk_i) disable iff (!mst_rst_n_d2_mst_clk)
    r_valid_q && !axil_req_i.r_ready |=> r_valid_q && $stable(r_data_q)
  ) else $error("r_valid dropped before r_ready");

endmodule

`default_nettype wire

//--- clk_divider.sv
`timescale 1ns/1ps
`default_nettype none

module clk_divider #(
  parameter clk_rst_pkg::div_t default_division = 8'd1
) (
  input  wire logic              mst_clk_i,
  input  wire logic              mst_rst_n_d2_mst_clk,
  input  wire clk_rst_pkg::div_t divisor_i,
  input  wire logic              apply_i,
  output logic                   clk_o
);

  import clk_rst_pkg::*;

  div_t pending_q;
  logic pending_valid_q;
  div_t active_q;
  div_t cnt_q;
  div_t active_d;
  div_t cnt_d;
  logic boundary;
  logic clk_q;

  // Last input cycle of the current output period
  assign boundary = (cnt_q == active_q - div_t'(1));

  always_comb begin
    active_d = active_q;
    cnt_d = cnt_q + div_t'(1);
    if (boundary) begin
      cnt_d = '0;
      if (pending_valid_q) begin
        active_d = pending_q;
      end
    end
  end

  always_ff @(posedge mst_clk_i or negedge mst_rst_n_d2_mst_clk) begin
    if (!mst_rst_n_d2_mst_clk) begin
      pending_valid_q <= 1'b0;
      active_q <= (default_division == '0) ? div_t'(1) : default_division;
      cnt_q <= '0;
      clk_q <= (default_division >= div_t'(2));
    end else begin
      active_q <= active_d;
      cnt_q <= cnt_d;
      // High for the first floor(d/2) cycles
      clk_q <= (cnt_d < (active_d >> 1));
      if (boundary) begin
        pending_valid_q <= 1'b0;
      end
      if (apply_i) begin
        pending_valid_q <= 1'b1;
      end
    end
  end

  // Zero behaves as one
  always_ff @(posedge mst_clk_i) begin
    if (apply_i) begin
      pending_q <= (divisor_i == '0) ? div_t'(1) : divisor_i;
    end
  end

  // Factor one passes the input clock straight through
  assign clk_o = (active_q == div_t'(1)) ? mst_clk_i : clk_q;

  cnt_in_range_a : assert property (
    @(posedge mst_clk_i) disable iff (!mst_rst_n_d2_mst_clk)
    cnt_q < active_q
  ) else $error("divider counter beyond active factor");

endmodule

`default_nettype wire

//--- rst_sync_delay.sv
`timescale 1ns/1ps
`default_nettype none

module rst_sync_delay #(
  parameter int unsigned num_stages = 2
) (
  input  wire logic clk_i,
  input  wire logic async_rst_ni,
  output logic      rst_no
);

  logic [num_stages-1:0] sync_q;

  // Clears at once and fills with ones one stage per clock
  always_ff @(posedge clk_i or negedge async_rst_ni) begin
    if (!async_rst_ni) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= 1'b1;
      for (int k = 1; k < num_stages; k++) begin
        sync_q[k] <= sync_q[k-1];
      end
    end
  end

  assign rst_no = sync_q[num_stages-1];

  // A seen reset cause keeps the output low through the following stages
  rst_no_held_a : assert property (
    @(posedge clk_i) !async_rst_ni |=> (!rst_no) [*num_stages-1]
  ) else $error("rst_no released before its stage count");

endmodule

`default_nettype wire

//--- clk_rst_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rst_ctrl_top (
  input  wire logic                          mst_clk_i,
  input  wire logic                          mst_rst_ni,
  input  wire clk_rst_pkg::axil_req_t        axil_req_i,
  output clk_rst_pkg::axil_rsp_t             axil_rsp_o,
  output logic [clk_rst_pkg::num_clocks-1:0] clk_o,
  output logic [clk_rst_pkg::num_clocks-1:0] rst_no
);

  import clk_rst_pkg::*;

  logic mst_rst_n_d1_mst_clk;
  logic mst_rst_n_d2_mst_clk;
  chan_ctrl_t [num_clocks-1:0] chan_ctrl;

  ////////////////////////////////////////////////////////////////////////////
  // Board reset synchronizer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge mst_clk_i or negedge mst_rst_ni) begin
    if (!mst_rst_ni) begin
      mst_rst_n_d1_mst_clk <= 1'b0;
      mst_rst_n_d2_mst_clk <= 1'b0;
    end else begin
      mst_rst_n_d1_mst_clk <= 1'b1;
      mst_rst_n_d2_mst_clk <= mst_rst_n_d1_mst_clk;
    end
  end

  clk_rst_axil_regs clk_rst_axil_regs_inst (
    .mst_clk_i           (mst_clk_i),
    .mst_rst_n_d2_mst_clk(mst_rst_n_d2_mst_clk),
    .axil_req_i          (axil_req_i),
    .axil_rsp_o          (axil_rsp_o),
    .chan_ctrl_o         (chan_ctrl)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output channels
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < num_clocks; i++) begin : gen_channel
    logic chan_rst_n;

    // Board reset or a software pulse clears the channel
    assign chan_rst_n = mst_rst_ni && !chan_ctrl[i].reset;

    clk_divider #(
      .default_division(default_division[i])
    ) clk_divider_inst (
      .mst_clk_i           (mst_clk_i),
      .mst_rst_n_d2_mst_clk(mst_rst_n_d2_mst_clk),
      .divisor_i           (chan_ctrl[i].divisor),
      .apply_i             (chan_ctrl[i].apply),
      .clk_o               (clk_o[i])
    );

    rst_sync_delay #(
      .num_stages(reset_stages[i])
    ) rst_sync_delay_inst (
      .clk_i       (clk_o[i]),
      .async_rst_ni(chan_rst_n),
      .rst_no      (rst_no[i])
    );
  end

endmodule

`default_nettype wire

//--- tb_clk_rst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_rst_ctrl;

  import clk_rst_pkg::*;

  localparam int clk_period = 20;
  localparam int max_factor = 32;
  localparam int n_txn = 200;
  localparam int txn_cycles = 24;
  localparam int n_meas = 24;
  localparam int watchdog_cycles = n_txn * txn_cycles + n_meas * 64 * max_factor;

  logic mst_clk_i;
  logic mst_rst_ni;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  logic [num_clocks-1:0] chan_clk;
  logic [num_clocks-1:0] chan_rst_n;

  integer seed;
  int errors;
  int checks;
  div_array_t exp_div;
  int exp_act [num_clocks];
  time t_rel [num_clocks];
  int edge_cnt [num_clocks];
  int rel_cnt [num_clocks];
  bit tie [num_clocks];
  bit fell [num_clocks];

  clk_rst_ctrl_top clk_rst_ctrl_top_inst (
    .mst_clk_i (mst_clk_i),
    .mst_rst_ni(mst_rst_ni),
    .axil_req_i(axil_req),
    .axil_rsp_o(axil_rsp),
    .clk_o     (chan_clk),
    .rst_no    (chan_rst_n)
  );

  initial begin
    mst_clk_i = 1'b0;
    forever #(clk_period / 2) mst_clk_i = ~mst_clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reset release tracking in channel clock edges after the cause is gone
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < num_clocks; g++) begin : gen_track
    always @(negedge chan_rst_n[g]) begin
      fell[g] = 1'b1;
      edge_cnt[g] = 0;
      tie[g] = 1'b0;
      rel_cnt[g] = -1;
      // Software pulse lasts one master clock cycle
      t_rel[g] = $time + clk_period;
    end
    always @(posedge chan_clk[g]) begin
      if ($time > t_rel[g]) begin
        edge_cnt[g]++;
      end else if ($time == t_rel[g]) begin
        tie[g] = 1'b1;
      end
    end
    always @(posedge chan_rst_n[g]) begin
      rel_cnt[g] = edge_cnt[g];
    end
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] exp_resp,
                            input string name);
    int delay;
    delay = $unsigned($random(seed)) % 8;
    @(posedge mst_clk_i);
    axil_req.aw_addr <= addr;
    axil_req.w_data <= data;
    axil_req.w_strb <= strb;
    axil_req.aw_valid <= 1'b1;
    axil_req.w_valid <= 1'b1;
    do @(posedge mst_clk_i); while (!axil_rsp.aw_ready && !axil_rsp.w_ready);
    if (axil_rsp.aw_ready !== axil_rsp.w_ready) begin
      errors++;
      $display("Write address and data for %s were not accepted together", name);
    end
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid <= 1'b0;
    repeat (delay) @(posedge mst_clk_i);
    axil_req.b_ready <= 1'b1;
    do @(posedge mst_clk_i); while (!axil_rsp.b_valid);
    axil_req.b_ready <= 1'b0;
    compare({name, "_resp"}, exp_resp, axil_rsp.b_resp);
    @(posedge mst_clk_i);
    if (axil_rsp.b_valid) begin
      errors++;
      $display("Write response for %s was given more than once", name);
    end
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int delay;
    delay = $unsigned($random(seed)) % 8;
    @(posedge mst_clk_i);
    axil_req.ar_addr <= addr;
    axil_req.ar_valid <= 1'b1;
    do @(posedge mst_clk_i); while (!axil_rsp.ar_ready);
    axil_req.ar_valid <= 1'b0;
    repeat (delay) @(posedge mst_clk_i);
    axil_req.r_ready <= 1'b1;
    do @(posedge mst_clk_i); while (!axil_rsp.r_valid);
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    axil_req.r_ready <= 1'b0;
    @(posedge mst_clk_i);
    if (axil_rsp.r_valid) begin
      errors++;
      $display("Read response at address %0h was given more than once", addr);
    end
  endtask

  // Period and high time in master clock cycles once the change settles
  task automatic measure_clock(input int ch, output int period, output int high);
    time t0;
    time t1;
    time t2;
    repeat (3) @(posedge chan_clk[ch]);
    t0 = $time;
    @(negedge chan_clk[ch]);
    t1 = $time;
    @(posedge chan_clk[ch]);
    t2 = $time;
    period = int'((t2 - t0) / clk_period);
    high = int'((t1 - t0) / clk_period);
  endtask

  task automatic check_periods(input string name);
    int period;
    int high;
    for (int i = 0; i < num_clocks; i++) begin
      measure_clock(i, period, high);
      compare($sformatf("%s_ch%0d", name, i), exp_act[i], period);
      if (exp_act[i] >= 2) begin
        compare($sformatf("%s_high_ch%0d", name, i), exp_act[i] / 2, high);
      end
    end
  endtask

  task automatic wait_release(input logic [num_clocks-1:0] mask);
    do @(posedge mst_clk_i); while ((chan_rst_n & mask) != mask);
  endtask

  task automatic check_release(input logic [num_clocks-1:0] mask, input string name);
    for (int i = 0; i < num_clocks; i++) begin
      if (mask[i]) begin
        checks++;
        // An edge exactly at the release time may or may not count
        if (rel_cnt[i] != int'(reset_stages[i]) &&
            !(tie[i] && rel_cnt[i] == int'(reset_stages[i]) - 1)) begin
          errors++;
          $display("Fail %s_ch%0d: expected %0d, actual %0d", name, i, reset_stages[i],
                   rel_cnt[i]);
        end
      end
    end
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge mst_clk_i);
    $display("Timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    logic [31:0] data;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic [3:0] strb;
    logic [num_clocks-1:0] mask;
    logic [num_clocks-1:0] fell_vec;
    seed = 32'heaed_64a5;
    errors = 0;
    checks = 0;
    mst_rst_ni = 1'b0;
    axil_req = '0;
    exp_div = default_division;
    for (int i = 0; i < num_clocks; i++) begin
      exp_act[i] = int'(default_division[i]);
    end
    repeat (7) @(posedge mst_clk_i);
    for (int i = 0; i < num_clocks; i++) begin
      edge_cnt[i] = 0;
      tie[i] = 1'b0;
      t_rel[i] = $time + clk_period;
    end
    @(posedge mst_clk_i);
    mst_rst_ni <= 1'b1;

    wait_release('1);
    // Idle bus after reset offers only a read address slot
    compare("reset_handshake", 32'h02,
            32'({axil_rsp.aw_ready, axil_rsp.w_ready, axil_rsp.b_valid,
                 axil_rsp.ar_ready, axil_rsp.r_valid}));
    check_release('1, "reset_release");
    check_periods("reset_period");

    ////////////////////////////////////////////////////////////////////////////
    // Division register with byte strobes
    ////////////////////////////////////////////////////////////////////////////
    repeat (16) begin
      data = $random(seed);
      strb = $random(seed);
      axil_write(addr_division, data, strb, axil_resp_okay, "division_write");
      for (int i = 0; i < num_clocks; i++) begin
        if (strb[i]) begin
          exp_div[i] = data[8*i +: 8];
        end
      end
      axil_read(addr_division, rdata, rresp);
      compare("division_read", exp_div, rdata);
      compare("division_read_resp", axil_resp_okay, rresp);
    end

    // Small factors so that 0 and 1 come up
    repeat (4) begin
      data = $random(seed) & 32'h1f1f_1f1f;
      mask = $random(seed);
      axil_write(addr_division, data, 4'hf, axil_resp_okay, "apply_division_write");
      exp_div = data;
      axil_write(addr_apply, 32'(mask), 4'hf, axil_resp_okay, "apply_write");
      axil_read(addr_apply, rdata, rresp);
      compare("apply_read", 32'h0, rdata);
      compare("apply_read_resp", axil_resp_okay, rresp);
      for (int i = 0; i < num_clocks; i++) begin
        if (mask[i]) begin
          exp_act[i] = (exp_div[i] == 0) ? 1 : int'(exp_div[i]);
        end
      end
      check_periods("applied_period");
    end

    repeat (3) begin
      mask = $random(seed);
      if (mask == 0) begin
        mask = 4'h1;
      end
      for (int i = 0; i < num_clocks; i++) begin
        fell[i] = 1'b0;
      end
      axil_write(addr_reset, 32'(mask), 4'hf, axil_resp_okay, "reset_write");
      axil_read(addr_reset, rdata, rresp);
      compare("reset_read", 32'h0, rdata);
      compare("reset_read_resp", axil_resp_okay, rresp);
      wait_release(mask);
      check_release(mask, "channel_release");
      for (int i = 0; i < num_clocks; i++) begin
        fell_vec[i] = fell[i];
      end
      compare("reset_select", 32'(mask), 32'(fell_vec));
    end

    data = $random(seed);
    axil_write(8'h0c, data, 4'hf, axil_resp_slverr, "unmapped_write");
    axil_read(8'h10, rdata, rresp);
    compare("unmapped_read", 32'h0, rdata);
    compare("unmapped_read_resp", axil_resp_slverr, rresp);
    repeat (8) begin
      axil_read(addr_division, rdata, rresp);
      compare("stalled_read", exp_div, rdata);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
clk_rst_pkg.sv
clk_rst_axil_regs.sv
clk_divider.sv
rst_sync_delay.sv
clk_rst_ctrl_top.sv
tb_clk_rst_ctrl.sv

//--- Bender.yml
package:
  name: clk_rst_ctrl

sources:
  - clk_rst_pkg.sv
  - clk_rst_axil_regs.sv
  - clk_divider.sv
  - rst_sync_delay.sv
  - clk_rst_ctrl_top.sv
  - target: test
    files:
      - tb_clk_rst_ctrl.sv
